/* include/mem_sys_consts.svh */
/*
  memory subsystem constants
  widths, memory size, host window base and the memory latency bound
*/
`ifndef MEM_SYS_CONSTS_SVH
`define MEM_SYS_CONSTS_SVH

// width of every command port address
`define MS_ADDR_W 16

// data path width
`define MS_DATA_W 32

// memory index bits, higher address bits alias
`define MS_MEM_AW 8

// core addresses from here up belong to the host device
`define MS_HOST_BASE 16'h8000

// worst case memory latency in cycles
`define MS_MAX_LAT 7

// console character width
`define MS_CHAR_W 8

`endif

/* src/mem_sys_pkg.sv */
/*
  memory subsystem types
  opcodes, handshake states and router targets shared by the blocks
*/
package mem_sys_pkg;

  // core and memory command opcode
  typedef enum logic {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  // loader record kinds
  typedef enum logic {
    LOAD_WR     = 1'b0,
    LOAD_FINISH = 1'b1
  } load_op_e;

  // four-phase responder progress
  typedef enum logic [1:0] {
    HS_IDLE = 2'b00,
    HS_BUSY = 2'b01,
    HS_DONE = 2'b10,
    HS_DROP = 2'b11
  } hs_state_e;

  // where the router sends a core command
  typedef enum logic {
    ROUTE_MEM  = 1'b0,
    ROUTE_HOST = 1'b1
  } route_e;

endpackage

/* src/sim_mem.sv */
/*
  simulated word memory
  answers each request after a pseudo-random latency from an LFSR
*/
`include "mem_sys_consts.svh"

module sim_mem
  (input  logic                     clk_i
  , input  logic                    rst_i
  , input  logic                    mem_req_i
  , input  mem_sys_pkg::mem_op_e    mem_op_i
  , input  logic [`MS_ADDR_W-1:0]   mem_addr_i
  , input  logic [`MS_DATA_W-1:0]   mem_wdata_i
  , output logic                    mem_ack_o
  , output logic [`MS_DATA_W-1:0]   mem_rdata_o
  );

  localparam int DEPTH = 1 << `MS_MEM_AW;
  localparam int CNT_W = $clog2(`MS_MAX_LAT + 1);

  logic [`MS_DATA_W-1:0] mem_q [0:DEPTH-1];
  logic [7:0]            lfsr_q;
  logic [CNT_W-1:0]      cnt_q;
  logic [CNT_W-1:0]      lat_seed;
  logic                  busy_q;
  logic                  ack_q;
  logic                  access;
  logic [`MS_MEM_AW-1:0] idx;

  // only the low address bits pick a word
  assign idx      = mem_addr_i[`MS_MEM_AW-1:0];
  // extra wait cycles, 0 to max-1
  assign lat_seed = CNT_W'(lfsr_q % `MS_MAX_LAT);
  // access fires as the countdown runs out
  assign access   = busy_q && (cnt_q == '0);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      lfsr_q <= 8'h5a;
      busy_q <= 1'b0;
      ack_q  <= 1'b0;
      cnt_q  <= '0;
    end
    else
    begin
      // taps 8,6,5,4, free running
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      if (!busy_q && !ack_q && mem_req_i)
      begin
        busy_q <= 1'b1;
        cnt_q  <= lat_seed;
      end
      else if (access)
      begin
        busy_q <= 1'b0;
        ack_q  <= 1'b1;
      end
      else if (busy_q)
        cnt_q <= cnt_q - 1'b1;
      // release one cycle after req falls
      else if (ack_q && !mem_req_i)
        ack_q <= 1'b0;
    end
  end

  // array starts out all zero
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem_q[i] <= '0;
    end
    else if (access && (mem_op_i == mem_sys_pkg::MEM_WR))
      mem_q[idx] <= mem_wdata_i;
  end

  // read data held for the whole ack phase
  always_ff @(posedge clk_i)
  begin
    if (access)
      mem_rdata_o <= (mem_op_i == mem_sys_pkg::MEM_WR) ? mem_wdata_i : mem_q[idx];
  end

  assign mem_ack_o = ack_q;

endmodule

/* src/mem_arbiter.sv */
/*
  round-robin memory arbiter
  grants the loader or the router one complete four-phase memory transaction
*/
`include "mem_sys_consts.svh"

module mem_arbiter
  (input  logic                     clk_i
  , input  logic                    rst_i
  // loader side, writes only
  , input  logic                    ld_req_i
  , input  logic [`MS_ADDR_W-1:0]   ld_addr_i
  , input  logic [`MS_DATA_W-1:0]   ld_wdata_i
  , output logic                    ld_ack_o
  // router side
  , input  logic                    rt_req_i
  , input  mem_sys_pkg::mem_op_e    rt_op_i
  , input  logic [`MS_ADDR_W-1:0]   rt_addr_i
  , input  logic [`MS_DATA_W-1:0]   rt_wdata_i
  , output logic                    rt_ack_o
  , output logic [`MS_DATA_W-1:0]   rt_rdata_o
  // memory side
  , output logic                    mem_req_o
  , output mem_sys_pkg::mem_op_e    mem_op_o
  , output logic [`MS_ADDR_W-1:0]   mem_addr_o
  , output logic [`MS_DATA_W-1:0]   mem_wdata_o
  , input  logic                    mem_ack_i
  , input  logic [`MS_DATA_W-1:0]   mem_rdata_i
  );

  mem_sys_pkg::hs_state_e state_q;
  // last granted peer, also the live grant during a transaction
  logic last_rt_q;
  logic pick_rt;
  logic win_ack;

  // router wins when alone or when the loader went last
  assign pick_rt = rt_req_i && (!ld_req_i || !last_rt_q);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q   <= mem_sys_pkg::HS_IDLE;
      last_rt_q <= 1'b0;
    end
    else
    begin
      unique case (state_q)
        mem_sys_pkg::HS_IDLE:
        begin
          if (ld_req_i || rt_req_i)
          begin
            last_rt_q <= pick_rt;
            state_q   <= mem_sys_pkg::HS_BUSY;
          end
        end
        // memory req high, waiting for its ack
        mem_sys_pkg::HS_BUSY:
        begin
          if (mem_ack_i)
            state_q <= mem_sys_pkg::HS_DONE;
        end
        // winner holds its req as long as it likes
        mem_sys_pkg::HS_DONE:
        begin
          if (!(last_rt_q ? rt_req_i : ld_req_i))
            state_q <= mem_sys_pkg::HS_DROP;
        end
        // memory req low, wait for the memory to let go
        mem_sys_pkg::HS_DROP:
        begin
          if (!mem_ack_i)
            state_q <= mem_sys_pkg::HS_IDLE;
        end
        default: state_q <= mem_sys_pkg::HS_IDLE;
      endcase
    end
  end

  // req goes out the cycle after the grant
  assign mem_req_o   = (state_q == mem_sys_pkg::HS_BUSY) || (state_q == mem_sys_pkg::HS_DONE);
  assign mem_op_o    = last_rt_q ? rt_op_i : mem_sys_pkg::MEM_WR;
  assign mem_addr_o  = last_rt_q ? rt_addr_i : ld_addr_i;
  assign mem_wdata_o = last_rt_q ? rt_wdata_i : ld_wdata_i;

  // winner ack follows the memory ack until req is dropped
  assign win_ack    = mem_ack_i && mem_req_o;
  assign ld_ack_o   = win_ack && !last_rt_q;
  assign rt_ack_o   = win_ack && last_rt_q;
  assign rt_rdata_o = mem_rdata_i;

endmodule

/* src/nbf_loader.sv */
/*
  boot image loader
  turns write records into memory writes and a finish record into a done flag
*/
`include "mem_sys_consts.svh"

module nbf_loader
  (input  logic                     clk_i
  , input  logic                    rst_i
  , input  logic                    load_req_i
  , input  mem_sys_pkg::load_op_e   load_op_i
  , input  logic [`MS_ADDR_W-1:0]   load_addr_i
  , input  logic [`MS_DATA_W-1:0]   load_data_i
  , output logic                    load_ack_o
  , output logic                    load_done_o
  , output logic                    ld_req_o
  , output logic [`MS_ADDR_W-1:0]   ld_addr_o
  , output logic [`MS_DATA_W-1:0]   ld_wdata_o
  , input  logic                    ld_ack_i
  );

  mem_sys_pkg::hs_state_e state_q;
  logic                   done_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q <= mem_sys_pkg::HS_IDLE;
      done_q  <= 1'b0;
    end
    else
    begin
      unique case (state_q)
        mem_sys_pkg::HS_IDLE:
        begin
          if (load_req_i && (load_op_i == mem_sys_pkg::LOAD_FINISH))
          begin
            // no memory access, sticky until reset
            done_q  <= 1'b1;
            state_q <= mem_sys_pkg::HS_DONE;
          end
          else if (load_req_i)
            state_q <= mem_sys_pkg::HS_BUSY;
        end
        // write in flight through the arbiter
        mem_sys_pkg::HS_BUSY:
        begin
          if (ld_ack_i)
            state_q <= mem_sys_pkg::HS_DROP;
        end
        mem_sys_pkg::HS_DROP:
        begin
          if (!ld_ack_i)
            state_q <= mem_sys_pkg::HS_DONE;
        end
        // record acked, wait for the testbench to drop req
        mem_sys_pkg::HS_DONE:
        begin
          if (!load_req_i)
            state_q <= mem_sys_pkg::HS_IDLE;
        end
        default: state_q <= mem_sys_pkg::HS_IDLE;
      endcase
    end
  end

  assign ld_req_o    = (state_q == mem_sys_pkg::HS_BUSY);
  // record fields stay stable while load req is high
  assign ld_addr_o   = load_addr_i;
  assign ld_wdata_o  = load_data_i;
  assign load_ack_o  = (state_q == mem_sys_pkg::HS_DONE);
  assign load_done_o = done_q;

endmodule

/* src/io_router.sv */
/*
  core command router
  sends core commands to memory or, at and above the host base, to the host device
*/
`include "mem_sys_consts.svh"

module io_router
  (input  logic                     clk_i
  , input  logic                    rst_i
  // core port
  , input  logic                    core_req_i
  , input  mem_sys_pkg::mem_op_e    core_op_i
  , input  logic [`MS_ADDR_W-1:0]   core_addr_i
  , input  logic [`MS_DATA_W-1:0]   core_wdata_i
  , output logic                    core_ack_o
  , output logic [`MS_DATA_W-1:0]   core_rdata_o
  // toward the memory arbiter
  , output logic                    rt_req_o
  , output mem_sys_pkg::mem_op_e    rt_op_o
  , output logic [`MS_ADDR_W-1:0]   rt_addr_o
  , output logic [`MS_DATA_W-1:0]   rt_wdata_o
  , input  logic                    rt_ack_i
  , input  logic [`MS_DATA_W-1:0]   rt_rdata_i
  // toward the host device
  , output logic                    host_req_o
  , output mem_sys_pkg::mem_op_e    host_op_o
  , output logic                    host_reg_o
  , output logic [`MS_DATA_W-1:0]   host_wdata_o
  , input  logic                    host_ack_i
  , input  logic [`MS_DATA_W-1:0]   host_rdata_i
  );

  mem_sys_pkg::hs_state_e state_q;
  mem_sys_pkg::route_e    route_q;
  logic [`MS_DATA_W-1:0]  rdata_q;
  logic                   tgt_ack;
  logic                   tgt_busy;

  // ack of whichever target this transaction picked
  assign tgt_ack  = (route_q == mem_sys_pkg::ROUTE_HOST) ? host_ack_i : rt_ack_i;
  assign tgt_busy = (state_q == mem_sys_pkg::HS_BUSY);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q <= mem_sys_pkg::HS_IDLE;
      route_q <= mem_sys_pkg::ROUTE_MEM;
    end
    else
    begin
      unique case (state_q)
        mem_sys_pkg::HS_IDLE:
        begin
          // decode once, route fixed for the whole exchange
          if (core_req_i)
          begin
            route_q <= (core_addr_i >= `MS_HOST_BASE) ? mem_sys_pkg::ROUTE_HOST
                                                      : mem_sys_pkg::ROUTE_MEM;
            state_q <= mem_sys_pkg::HS_BUSY;
          end
        end
        mem_sys_pkg::HS_BUSY:
        begin
          if (tgt_ack)
            state_q <= mem_sys_pkg::HS_DROP;
        end
        // target req low, wait out its ack
        mem_sys_pkg::HS_DROP:
        begin
          if (!tgt_ack)
            state_q <= mem_sys_pkg::HS_DONE;
        end
        mem_sys_pkg::HS_DONE:
        begin
          if (!core_req_i)
            state_q <= mem_sys_pkg::HS_IDLE;
        end
        default: state_q <= mem_sys_pkg::HS_IDLE;
      endcase
    end
  end

  // capture target data on its ack
  always_ff @(posedge clk_i)
  begin
    if (tgt_busy && tgt_ack)
      rdata_q <= (route_q == mem_sys_pkg::ROUTE_HOST) ? host_rdata_i : rt_rdata_i;
  end

  assign rt_req_o     = tgt_busy && (route_q == mem_sys_pkg::ROUTE_MEM);
  assign rt_op_o      = core_op_i;
  assign rt_addr_o    = core_addr_i;
  assign rt_wdata_o   = core_wdata_i;
  assign host_req_o   = tgt_busy && (route_q == mem_sys_pkg::ROUTE_HOST);
  assign host_op_o    = core_op_i;
  // bit 0 picks console or finish register
  assign host_reg_o   = core_addr_i[0];
  assign host_wdata_o = core_wdata_i;
  assign core_ack_o   = (state_q == mem_sys_pkg::HS_DONE);
  assign core_rdata_o = rdata_q;

endmodule

/* src/host_dev.sv */
/*
  host device
  console character register with a counter, plus a sticky program finish flag
*/
`include "mem_sys_consts.svh"

module host_dev
  (input  logic                     clk_i
  , input  logic                    rst_i
  , input  logic                    host_req_i
  , input  mem_sys_pkg::mem_op_e    host_op_i
  , input  logic                    host_reg_i
  , input  logic [`MS_DATA_W-1:0]   host_wdata_i
  , output logic                    host_ack_o
  , output logic [`MS_DATA_W-1:0]   host_rdata_o
  , output logic                    putchar_v_o
  , output logic [`MS_CHAR_W-1:0]   putchar_o
  , output logic                    program_finish_o
  );

  logic                  ack_q;
  logic                  finish_q;
  logic [`MS_DATA_W-1:0] char_cnt_q;
  logic                  acc;
  logic                  wr;

  // one access per request, on the cycle ack rises
  assign acc = host_req_i && !ack_q;
  assign wr  = acc && (host_op_i == mem_sys_pkg::MEM_WR);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ack_q       <= 1'b0;
      finish_q    <= 1'b0;
      char_cnt_q  <= '0;
      putchar_v_o <= 1'b0;
    end
    else
    begin
      ack_q       <= host_req_i;
      // single cycle strobe per console write
      putchar_v_o <= wr && !host_reg_i;
      if (wr && !host_reg_i)
        char_cnt_q <= char_cnt_q + 1'b1;
      if (wr && host_reg_i)
        finish_q <= 1'b1;
    end
  end

  // reg 0 reads the count, reg 1 the flag in bit 0
  always_ff @(posedge clk_i)
  begin
    if (acc)
      host_rdata_o <= host_reg_i ? {{(`MS_DATA_W-1){1'b0}}, finish_q} : char_cnt_q;
    if (wr && !host_reg_i)
      putchar_o <= host_wdata_i[`MS_CHAR_W-1:0];
  end

  assign host_ack_o       = ack_q;
  assign program_finish_o = finish_q;

endmodule

/* src/mem_sys_top.sv */
/*
  memory and I/O subsystem top
  loader and core router share one memory through the arbiter, host sits on the router
*/
`include "mem_sys_consts.svh"

module mem_sys_top
  (input  logic                     clk_i
  , input  logic                    rst_i
  // load port
  , input  logic                    load_req_i
  , input  mem_sys_pkg::load_op_e   load_op_i
  , input  logic [`MS_ADDR_W-1:0]   load_addr_i
  , input  logic [`MS_DATA_W-1:0]   load_data_i
  , output logic                    load_ack_o
  // core port
  , input  logic                    core_req_i
  , input  mem_sys_pkg::mem_op_e    core_op_i
  , input  logic [`MS_ADDR_W-1:0]   core_addr_i
  , input  logic [`MS_DATA_W-1:0]   core_wdata_i
  , output logic                    core_ack_o
  , output logic [`MS_DATA_W-1:0]   core_rdata_o
  // status
  , output logic                    load_done_o
  , output logic                    program_finish_o
  , output logic                    putchar_v_o
  , output logic [`MS_CHAR_W-1:0]   putchar_o
  );

  // loader to arbiter
  logic                  ld_req;
  logic [`MS_ADDR_W-1:0] ld_addr;
  logic [`MS_DATA_W-1:0] ld_wdata;
  logic                  ld_ack;
  // router to arbiter
  logic                  rt_req;
  mem_sys_pkg::mem_op_e  rt_op;
  logic [`MS_ADDR_W-1:0] rt_addr;
  logic [`MS_DATA_W-1:0] rt_wdata;
  logic                  rt_ack;
  logic [`MS_DATA_W-1:0] rt_rdata;
  // arbiter to memory
  logic                  mem_req;
  mem_sys_pkg::mem_op_e  mem_op;
  logic [`MS_ADDR_W-1:0] mem_addr;
  logic [`MS_DATA_W-1:0] mem_wdata;
  logic                  mem_ack;
  logic [`MS_DATA_W-1:0] mem_rdata;
  // router to host
  logic                  host_req;
  mem_sys_pkg::mem_op_e  host_op;
  logic                  host_reg;
  logic [`MS_DATA_W-1:0] host_wdata;
  logic                  host_ack;
  logic [`MS_DATA_W-1:0] host_rdata;

  nbf_loader loader
    (.clk_i, .rst_i, .load_req_i, .load_op_i, .load_addr_i, .load_data_i, .load_ack_o
    , .load_done_o
    , .ld_req_o(ld_req), .ld_addr_o(ld_addr), .ld_wdata_o(ld_wdata), .ld_ack_i(ld_ack));

  io_router router
    (.clk_i, .rst_i, .core_req_i, .core_op_i, .core_addr_i, .core_wdata_i
    , .core_ack_o, .core_rdata_o
    , .rt_req_o(rt_req), .rt_op_o(rt_op), .rt_addr_o(rt_addr), .rt_wdata_o(rt_wdata)
    , .rt_ack_i(rt_ack), .rt_rdata_i(rt_rdata)
    , .host_req_o(host_req), .host_op_o(host_op), .host_reg_o(host_reg)
    , .host_wdata_o(host_wdata), .host_ack_i(host_ack), .host_rdata_i(host_rdata));

  mem_arbiter arbiter
    (.clk_i, .rst_i
    , .ld_req_i(ld_req), .ld_addr_i(ld_addr), .ld_wdata_i(ld_wdata), .ld_ack_o(ld_ack)
    , .rt_req_i(rt_req), .rt_op_i(rt_op), .rt_addr_i(rt_addr), .rt_wdata_i(rt_wdata)
    , .rt_ack_o(rt_ack), .rt_rdata_o(rt_rdata)
    , .mem_req_o(mem_req), .mem_op_o(mem_op), .mem_addr_o(mem_addr)
    , .mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata));

  sim_mem mem
    (.clk_i, .rst_i, .mem_req_i(mem_req), .mem_op_i(mem_op), .mem_addr_i(mem_addr)
    , .mem_wdata_i(mem_wdata), .mem_ack_o(mem_ack), .mem_rdata_o(mem_rdata));

  host_dev host
    (.clk_i, .rst_i, .host_req_i(host_req), .host_op_i(host_op), .host_reg_i(host_reg)
    , .host_wdata_i(host_wdata), .host_ack_o(host_ack), .host_rdata_o(host_rdata)
    , .putchar_v_o, .putchar_o, .program_finish_o);

endmodule

/* sim/tb_clock.sv */
/*
  testbench clock and reset
  40 ns clock, reset held high for the first three cycles
*/
module tb_clock
  (output logic clk_o
  , output logic rst_o
  );

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // release a little after the third rising edge
  initial
  begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #2 rst_o = 1'b0;
  end

endmodule

/* sim/tb_mem_sys.sv */
/*
  memory subsystem testbench
  random core and loader traffic against a memory and host model, with a watchdog
*/
`include "mem_sys_consts.svh"

module tb_mem_sys;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_ZERO = 16;
  localparam int N_RW   = 200;
  localparam int N_IMG  = 128;
  localparam int N_CONC = 96;
  localparam int N_CHAR = 24;
  // every core and load transaction of the run, plus a few host accesses
  localparam int N_TXN  = N_ZERO + N_RW + N_IMG + 1 + N_CONC + N_IMG + N_CHAR + 10;
  localparam int WD_CYCLES = N_TXN * (`MS_MAX_LAT + 8) + 200;

  logic                   clk;
  logic                   rst;
  logic                   load_req;
  mem_sys_pkg::load_op_e  load_op;
  logic [`MS_ADDR_W-1:0]  load_addr;
  logic [`MS_DATA_W-1:0]  load_data;
  logic                   load_ack_o;
  logic                   core_req;
  mem_sys_pkg::mem_op_e   core_op;
  logic [`MS_ADDR_W-1:0]  core_addr;
  logic [`MS_DATA_W-1:0]  core_wdata;
  logic                   core_ack_o;
  logic [`MS_DATA_W-1:0]  core_rdata_o;
  logic                   load_done_o;
  logic                   program_finish_o;
  logic                   putchar_v_o;
  logic [`MS_CHAR_W-1:0]  putchar_o;

  // reference model
  logic [`MS_DATA_W-1:0]  model [0:(1<<`MS_MEM_AW)-1];
  logic [`MS_DATA_W-1:0]  img [0:N_IMG-1];
  logic [`MS_ADDR_W-1:0]  conc_addr [0:N_CONC-1];
  logic [`MS_DATA_W-1:0]  conc_data [0:N_CONC-1];
  logic                   conc_wr [0:N_CONC-1];
  logic [`MS_CHAR_W-1:0]  exp_chars [$];
  logic [`MS_CHAR_W-1:0]  exp_c;
  int                     char_cnt;
  int                     pulses;
  int                     errors;

  tb_clock clock_gen (.clk_o(clk), .rst_o(rst));

  mem_sys_top uut
    (.clk_i(clk), .rst_i(rst)
    , .load_req_i(load_req), .load_op_i(load_op), .load_addr_i(load_addr)
    , .load_data_i(load_data), .load_ack_o(load_ack_o)
    , .core_req_i(core_req), .core_op_i(core_op), .core_addr_i(core_addr)
    , .core_wdata_i(core_wdata), .core_ack_o(core_ack_o), .core_rdata_o(core_rdata_o)
    , .load_done_o(load_done_o), .program_finish_o(program_finish_o)
    , .putchar_v_o(putchar_v_o), .putchar_o(putchar_o));

  task automatic report_mismatch(input string what, input logic [`MS_ADDR_W-1:0] addr,
                                 input logic [`MS_DATA_W-1:0] got,
                                 input logic [`MS_DATA_W-1:0] exp);
    errors++;
    $display("ERR %0t: %s at %h got %h expected %h", $time, what, addr, got, exp);
  endtask

  // one four-phase core exchange, entered and left 2 ns after an edge
  task automatic core_xfer(input mem_sys_pkg::mem_op_e op, input logic [`MS_ADDR_W-1:0] addr,
                           input logic [`MS_DATA_W-1:0] wdata,
                           output logic [`MS_DATA_W-1:0] rdata);
    core_op    = op;
    core_addr  = addr;
    core_wdata = wdata;
    core_req   = 1'b1;
    do
    begin
      @(posedge clk);
      #2;
    end
    while (!core_ack_o);
    rdata    = core_rdata_o;
    core_req = 1'b0;
    do
    begin
      @(posedge clk);
      #2;
    end
    while (core_ack_o);
  endtask

  // one loader record, same four phases
  task automatic load_rec(input mem_sys_pkg::load_op_e op, input logic [`MS_ADDR_W-1:0] addr,
                          input logic [`MS_DATA_W-1:0] data);
    load_op   = op;
    load_addr = addr;
    load_data = data;
    load_req  = 1'b1;
    do
    begin
      @(posedge clk);
      #2;
    end
    while (!load_ack_o);
    load_req = 1'b0;
    do
    begin
      @(posedge clk);
      #2;
    end
    while (load_ack_o);
  endtask

  // console strobes, each one checked against the queued character
  always @(posedge clk)
  begin
    #2;
    if (!rst && putchar_v_o)
    begin
      pulses++;
      if (exp_chars.size() == 0)
      begin
        errors++;
        $display("console strobe at %0t with no console write pending", $time);
      end
      else
      begin
        exp_c = exp_chars.pop_front();
        if (putchar_o !== exp_c)
          report_mismatch("console character", 16'h8000, 32'(putchar_o), 32'(exp_c));
      end
    end
  end

  initial
  begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, DUT hung with %0d errors", WD_CYCLES, errors);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    logic [`MS_ADDR_W-1:0] addr;
    logic [`MS_DATA_W-1:0] data;
    logic [`MS_DATA_W-1:0] rd;
    load_req   = 1'b0;
    load_op    = mem_sys_pkg::LOAD_WR;
    load_addr  = '0;
    load_data  = '0;
    core_req   = 1'b0;
    core_op    = mem_sys_pkg::MEM_RD;
    core_addr  = '0;
    core_wdata = '0;
    errors     = 0;
    pulses     = 0;
    char_cnt   = 0;
    void'($urandom(32'hf0f5cf21));
    for (int i = 0; i < (1 << `MS_MEM_AW); i++)
      model[i] = '0;
    // all random values drawn up front, one stream
    for (int i = 0; i < N_IMG; i++)
      img[i] = $urandom;
    for (int i = 0; i < N_CONC; i++)
    begin
      // words 0 to 127 with random upper bits
      conc_addr[i] = {1'b0, 7'($urandom), 1'b0, 7'($urandom)};
      conc_data[i] = $urandom;
      conc_wr[i]   = 1'($urandom);
    end
    wait (!rst);
    @(posedge clk);
    #2;

    if (load_done_o || program_finish_o || putchar_v_o || load_ack_o || core_ack_o)
      report_mismatch("status after reset", '0, 32'({load_done_o, program_finish_o,
                      putchar_v_o, load_ack_o, core_ack_o}), '0);

    // reads straight after reset
    for (int i = 0; i < N_ZERO; i++)
    begin
      addr = 16'($urandom) & 16'h7fff;
      core_xfer(mem_sys_pkg::MEM_RD, addr, '0, rd);
      if (rd !== '0)
        report_mismatch("read after reset", addr, rd, '0);
    end

    // random core traffic, low index 0 to 31 so upper bits alias a lot
    for (int i = 0; i < N_RW; i++)
    begin
      addr = {1'b0, 7'($urandom), 3'b000, 5'($urandom)};
      data = $urandom;
      if ($urandom_range(1, 0) == 1)
      begin
        core_xfer(mem_sys_pkg::MEM_WR, addr, data, rd);
        model[addr[`MS_MEM_AW-1:0]] = data;
      end
      else
      begin
        core_xfer(mem_sys_pkg::MEM_RD, addr, '0, rd);
        if (rd !== model[addr[`MS_MEM_AW-1:0]])
          report_mismatch("core read", addr, rd, model[addr[`MS_MEM_AW-1:0]]);
      end
    end

    // loader fills the upper half while the core works the lower half
    fork
      begin
        for (int i = 0; i < N_IMG; i++)
        begin
          if (load_done_o !== 1'b0)
            report_mismatch("load done before finish", 16'(128 + i), 32'(load_done_o), '0);
          load_rec(mem_sys_pkg::LOAD_WR, 16'(128 + i), img[i]);
          model[128 + i] = img[i];
        end
        if (load_done_o !== 1'b0)
          report_mismatch("load done before finish", '0, 32'(load_done_o), '0);
        load_rec(mem_sys_pkg::LOAD_FINISH, '0, '0);
        if (load_done_o !== 1'b1)
          report_mismatch("load done after finish", '0, 32'(load_done_o), 32'd1);
      end
      begin
        for (int i = 0; i < N_CONC; i++)
        begin
          if (conc_wr[i])
          begin
            core_xfer(mem_sys_pkg::MEM_WR, conc_addr[i], conc_data[i], rd);
            model[conc_addr[i][`MS_MEM_AW-1:0]] = conc_data[i];
          end
          else
          begin
            core_xfer(mem_sys_pkg::MEM_RD, conc_addr[i], '0, rd);
            if (rd !== model[conc_addr[i][`MS_MEM_AW-1:0]])
              report_mismatch("concurrent core read", conc_addr[i], rd,
                              model[conc_addr[i][`MS_MEM_AW-1:0]]);
          end
        end
      end
    join

    // image readback through the core port
    for (int i = 0; i < N_IMG; i++)
    begin
      addr = {1'b0, 7'($urandom), 8'(128 + i)};
      core_xfer(mem_sys_pkg::MEM_RD, addr, '0, rd);
      if (rd !== img[i])
        report_mismatch("image readback", addr, rd, img[i]);
    end

    // console writes, any even host address hits register 0
    for (int i = 0; i < N_CHAR; i++)
    begin
      addr = 16'h8000 | (16'($urandom) & 16'h7ffe);
      data = $urandom;
      exp_chars.push_back(data[`MS_CHAR_W-1:0]);
      core_xfer(mem_sys_pkg::MEM_WR, addr, data, rd);
      char_cnt++;
    end
    core_xfer(mem_sys_pkg::MEM_RD, 16'h8000, '0, rd);
    if (rd !== 32'(char_cnt))
      report_mismatch("character count", 16'h8000, rd, 32'(char_cnt));

    // finish register
    core_xfer(mem_sys_pkg::MEM_RD, 16'h8001, '0, rd);
    if (rd !== '0 || program_finish_o !== 1'b0)
      report_mismatch("finish before write", 16'h8001, rd, '0);
    core_xfer(mem_sys_pkg::MEM_WR, 16'hc0a1, $urandom, rd);
    if (program_finish_o !== 1'b1)
      report_mismatch("finish flag", 16'hc0a1, 32'(program_finish_o), 32'd1);
    core_xfer(mem_sys_pkg::MEM_RD, 16'h8001, '0, rd);
    if (rd !== 32'd1)
      report_mismatch("finish read", 16'h8001, rd, 32'd1);

    // memory still reachable, both flags still sticky
    data = $urandom;
    core_xfer(mem_sys_pkg::MEM_WR, 16'h0042, data, rd);
    core_xfer(mem_sys_pkg::MEM_RD, 16'h0042, '0, rd);
    if (rd !== data)
      report_mismatch("core read after finish", 16'h0042, rd, data);
    core_xfer(mem_sys_pkg::MEM_RD, 16'h8000, '0, rd);
    if (rd !== 32'(char_cnt))
      report_mismatch("character count after finish", 16'h8000, rd, 32'(char_cnt));
    if (program_finish_o !== 1'b1 || load_done_o !== 1'b1)
      report_mismatch("sticky flags", '0, 32'({load_done_o, program_finish_o}), 32'd3);

    if (exp_chars.size() != 0 || pulses != char_cnt)
    begin
      errors++;
      $display("console saw %0d strobes for %0d writes", pulses, char_cnt);
    end

    $display("run complete, %0d errors", errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* project.f */
+incdir+include
src/mem_sys_pkg.sv
src/sim_mem.sv
src/mem_arbiter.sv
src/nbf_loader.sv
src/io_router.sv
src/host_dev.sv
src/mem_sys_top.sv
sim/tb_clock.sv
sim/tb_mem_sys.sv

/* Bender.yml */
package:
  name: mem_sys

sources:
  - include_dirs:
      - include
    files:
      - src/mem_sys_pkg.sv
      - src/sim_mem.sv
      - src/mem_arbiter.sv
      - src/nbf_loader.sv
      - src/io_router.sv
      - src/host_dev.sv
      - src/mem_sys_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_clock.sv
      - sim/tb_mem_sys.sv
